// File: filelist.f
+incdir+common
common/rv_pkg.sv
fetch/fetch_stage.sv
decode/inst_decoder.sv
decode/reg_file.sv
execute/execute_stage.sv
logic/rv_core.sv
tb/rv_core_tb.sv

// File: Makefile
TOP = rv_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

// File: tb/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_core_tb
    import rv_pkg::*;
();

    localparam int         PROG_LEN  = 200;
    localparam imem_addr_t PROG_END  = 30'd200;
    localparam imem_addr_t BURST_LO  = 30'd100; // stall-free window
    localparam imem_addr_t BURST_HI  = 30'd120;
    localparam int         CYC_LIMIT = 2 * PROG_LEN + 50;

    logic       clk;
    logic       rst_n;
    word_t      i_imem_rdata;
    logic       i_imem_stall = 1'b0;
    imem_addr_t o_imem_addr;
    word_t      o_pc;
    logic       o_wb_valid;
    reg_addr_t  o_wb_rd;
    word_t      o_wb_data;

    word_t      imem     [0:255]; // program stored byte-reversed
    reg_addr_t  prog_rd  [0:255];
    reg_addr_t  exp_rd   [0:255]; // expected retirements in program order
    word_t      exp_data [0:255];
    logic [7:0] exp_count = '0;
    logic [7:0] ret_idx = '0;
    int         post_rst_cyc = 0;
    int         cyc = 0;
    int         stall_cnt = 0;
    int         dep1 = 0;
    int         dep2 = 0;
    int         dep3 = 0;
    int         f_reset = 0;
    int         f_value = 0;
    int         f_count = 0;
    int         f_stall = 0;
    int         f_latency = 0;

    logic       in_burst;
    reg_addr_t  fetch_rd;
    logic       fetch_writes;
    logic [2:0] lat_burst = '0;
    logic [2:0] lat_writes = '0;
    reg_addr_t  lat_rd [0:2];
    logic       prev_stall = 1'b0;
    imem_addr_t prev_addr = '0;
    word_t      exp_pc = `RV_RESET_PC; // pc model stepping by four on unstalled cycles

    function automatic word_t byte_rev(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // RV32I semantics of the nine operations
    function automatic word_t isa_alu(input alu_op_e op, input word_t a, input word_t b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_SLL: return a << b[4:0];
            ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_XOR: return a ^ b;
            ALU_SRL: return a >> b[4:0];
            ALU_SRA: return word_t'($signed(a) >>> b[4:0]);
            ALU_OR:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [2:0] funct3_of(input alu_op_e op);
        case (op)
            ALU_ADD, ALU_SUB: return 3'b000;
            ALU_SLL:          return 3'b001;
            ALU_SLT:          return 3'b010;
            ALU_XOR:          return 3'b100;
            ALU_SRL, ALU_SRA: return 3'b101;
            ALU_OR:           return 3'b110;
            default:          return 3'b111;
        endcase
    endfunction

    // producer rd feeds a source the consumer really reads
    function automatic logic has_dep(input reg_addr_t prod, input reg_addr_t rs1,
                                     input reg_addr_t rs2, input logic use_i);
        return (prod != '0) && ((prod == rs1) || (!use_i && (prod == rs2)));
    endfunction

    task automatic build_program();
        word_t       regs [0:31];
        alu_op_e     op;
        logic        use_i;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [11:0] imm;
        logic [6:0]  f7;
        word_t       inst;
        word_t       b;
        word_t       res;
        regs = '{default: '0};
        for (int i = 0; i < PROG_LEN; i++) begin
            op    = alu_op_e'($urandom_range(0, 8));
            use_i = (op != ALU_SUB) && ($urandom_range(0, 1) == 1);
            rd    = reg_addr_t'($urandom_range(0, 5)); // x0..x5 keeps hazards dense
            rs1   = reg_addr_t'($urandom_range(0, 5));
            rs2   = reg_addr_t'($urandom_range(0, 5));
            imm   = 12'($urandom_range(0, 4095));
            f7    = (op == ALU_SUB || op == ALU_SRA) ? 7'h20 : 7'h00;
            if (use_i) begin
                if (op == ALU_SLL || op == ALU_SRL || op == ALU_SRA) begin
                    imm = {f7, imm[4:0]}; // shamt form
                end
                inst = {imm, rs1, funct3_of(op), rd, OPC_OP_IMM};
                b    = {{20{imm[11]}}, imm};
            end else begin
                inst = {f7, rs2, rs1, funct3_of(op), rd, OPC_OP};
                b    = regs[rs2];
            end
            res = isa_alu(op, regs[rs1], b);
            if (i >= 1 && has_dep(prog_rd[8'(i - 1)], rs1, rs2, use_i)) begin
                dep1++;
            end
            if (i >= 2 && has_dep(prog_rd[8'(i - 2)], rs1, rs2, use_i)) begin
                dep2++;
            end
            if (i >= 3 && has_dep(prog_rd[8'(i - 3)], rs1, rs2, use_i)) begin
                dep3++;
            end
            if (rd != '0) begin
                regs[rd]            = res;
                exp_rd[exp_count]   = rd;
                exp_data[exp_count] = res;
                exp_count++;
            end
            prog_rd[i[7:0]] = rd;
            imem[i[7:0]]    = byte_rev(inst);
        end
    endtask

    rv_core uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_imem_rdata (i_imem_rdata),
        .i_imem_stall (i_imem_stall),
        .o_imem_addr  (o_imem_addr),
        .o_pc         (o_pc),
        .o_wb_valid   (o_wb_valid),
        .o_wb_rd      (o_wb_rd),
        .o_wb_data    (o_wb_data)
    );

    // combinational instruction memory with NOPs past the program
    assign i_imem_rdata = (o_imem_addr < PROG_END) ? imem[o_imem_addr[7:0]]
                                                   : byte_rev(`RV_NOP);

    assign in_burst     = (o_imem_addr >= BURST_LO) && (o_imem_addr < BURST_HI);
    assign fetch_rd     = (o_imem_addr < PROG_END) ? prog_rd[o_imem_addr[7:0]] : '0;
    assign fetch_writes = !i_imem_stall && (fetch_rd != '0);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(negedge clk) begin
        if (post_rst_cyc > 0 && !in_burst) begin
            i_imem_stall = ($urandom_range(0, 7) == 0); // about one cycle in eight
        end else begin
            i_imem_stall = 1'b0;
        end
    end

    always @(posedge clk) begin
        cyc        <= cyc + 1;
        lat_burst  <= {lat_burst[1:0], in_burst && rst_n}; // fetch info delayed 3 cycles
        lat_writes <= {lat_writes[1:0], fetch_writes};
        lat_rd[0]  <= fetch_rd;
        lat_rd[1]  <= lat_rd[0];
        lat_rd[2]  <= lat_rd[1];
        prev_stall <= i_imem_stall;
        prev_addr  <= o_imem_addr;
        if (!rst_n) begin
            post_rst_cyc <= 0;
            ret_idx      <= '0;
            exp_pc       <= `RV_RESET_PC;
        end else begin
            post_rst_cyc <= (post_rst_cyc < 1000) ? post_rst_cyc + 1 : post_rst_cyc;
            if (o_wb_valid) begin
                ret_idx <= ret_idx + 8'd1;
            end
            if (i_imem_stall) begin
                stall_cnt <= stall_cnt + 1;
            end else begin
                exp_pc <= exp_pc + 32'd4;
            end
        end
        if (cyc >= CYC_LIMIT) begin
            $display("timeout: program did not drain within %0d cycles", CYC_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    a_reset_addr: assert property (@(posedge clk) (post_rst_cyc == 0) |-> (o_imem_addr == '0))
        else begin
            $display("CHECK FAILED: o_imem_addr expected %h got %h", 30'h0, $sampled(o_imem_addr));
            f_reset++;
        end

    a_reset_idle: assert property (@(posedge clk) (post_rst_cyc < 3) |-> !o_wb_valid)
        else begin
            $display("CHECK FAILED: o_wb_valid expected %h got %h", 1'b0, $sampled(o_wb_valid));
            f_reset++;
        end

    a_ret_expected: assert property (@(posedge clk) disable iff (!rst_n)
        o_wb_valid |-> (ret_idx < exp_count))
        else begin
            $display("retirement seen after every expected instruction had retired");
            f_count++;
        end

    a_ret_rd: assert property (@(posedge clk) disable iff (!rst_n)
        (o_wb_valid && (ret_idx < exp_count)) |-> (o_wb_rd == exp_rd[ret_idx]))
        else begin
            $display("CHECK FAILED: o_wb_rd expected %h got %h",
                     $sampled(exp_rd[ret_idx]), $sampled(o_wb_rd));
            f_value++;
        end

    a_ret_data: assert property (@(posedge clk) disable iff (!rst_n)
        (o_wb_valid && (ret_idx < exp_count)) |-> (o_wb_data == exp_data[ret_idx]))
        else begin
            $display("CHECK FAILED: o_wb_data expected %h got %h",
                     $sampled(exp_data[ret_idx]), $sampled(o_wb_data));
            f_value++;
        end

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        prev_stall |-> (o_imem_addr == prev_addr))
        else begin
            $display("CHECK FAILED: o_imem_addr expected %h got %h",
                     $sampled(prev_addr), $sampled(o_imem_addr));
            f_stall++;
        end

    a_pc_track: assert property (@(posedge clk) disable iff (!rst_n)
        o_pc == exp_pc)
        else begin
            $display("CHECK FAILED: o_pc expected %h got %h",
                     $sampled(exp_pc), $sampled(o_pc));
            f_stall++;
        end

    a_latency_valid: assert property (@(posedge clk) disable iff (!rst_n)
        lat_burst[2] |-> (o_wb_valid == lat_writes[2]))
        else begin
            $display("CHECK FAILED: o_wb_valid expected %h got %h",
                     $sampled(lat_writes[2]), $sampled(o_wb_valid));
            f_latency++;
        end

    a_latency_rd: assert property (@(posedge clk) disable iff (!rst_n)
        (lat_burst[2] && o_wb_valid) |-> (o_wb_rd == lat_rd[2]))
        else begin
            $display("CHECK FAILED: o_wb_rd expected %h got %h",
                     $sampled(lat_rd[2]), $sampled(o_wb_rd));
            f_latency++;
        end

    initial begin
        int total;
        rst_n = 1'b0;
        void'($urandom(32'had42ca7a));
        build_program();
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk); // first retirement possible after this
        $display("test 1 reset: %0d failures", f_reset);
        while (o_imem_addr < BURST_HI + 30'd3) begin
            @(negedge clk);
        end
        $display("test 6 latency burst: %0d failures", f_latency);
        while (o_imem_addr < PROG_END + 30'd4) begin
            @(negedge clk);
        end
        $display("test 2 alu results: %0d retired, %0d failures", ret_idx, f_value);
        $display("test 3 dependencies: dist1 %0d dist2 %0d dist3 %0d, %0d failures",
                 dep1, dep2, dep3, f_value);
        a_all_retired: assert (ret_idx == exp_count)
            else begin
                $display("CHECK FAILED: retired count expected %h got %h", exp_count, ret_idx);
                f_count++;
            end
        $display("test 4 retirement count: %0d failures", f_count);
        $display("test 5 stall: %0d stall cycles, %0d failures", stall_cnt, f_stall);
        total = f_reset + f_value + f_count + f_stall + f_latency;
        $display("summary: 6 tests, %0d of %0d retirements, %0d failures",
                 ret_idx, exp_count, total);
        if (total == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: logic/rv_core.sv
`timescale 1ns/1ps

module rv_core
    import rv_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  word_t      i_imem_rdata,
    input  logic       i_imem_stall,
    output imem_addr_t o_imem_addr,
    output word_t      o_pc,
    output logic       o_wb_valid,
    output reg_addr_t  o_wb_rd,
    output word_t      o_wb_data
);

    word_t     f_inst;
    reg_addr_t dec_rs1_addr;
    reg_addr_t dec_rs2_addr;
    reg_addr_t dec_rd_addr;
    word_t     dec_imm;
    alu_op_e   dec_alu_op;
    logic      dec_use_imm;
    logic      dec_reg_write;
    word_t     rf_rs1_data;
    word_t     rf_rs2_data;

    fetch_stage u_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_imem_rdata (i_imem_rdata),
        .i_imem_stall (i_imem_stall),
        .o_imem_addr  (o_imem_addr),
        .o_pc         (o_pc),
        .o_inst       (f_inst)
    );

    inst_decoder u_dec (
        .i_inst      (f_inst),
        .o_rs1_addr  (dec_rs1_addr),
        .o_rs2_addr  (dec_rs2_addr),
        .o_rd_addr   (dec_rd_addr),
        .o_imm       (dec_imm),
        .o_alu_op    (dec_alu_op),
        .o_use_imm   (dec_use_imm),
        .o_reg_write (dec_reg_write)
    );

    // write port is fed straight from the retirement port
    reg_file u_rf (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_rs1_addr (dec_rs1_addr),
        .i_rs2_addr (dec_rs2_addr),
        .i_wr_addr  (o_wb_rd),
        .i_wr_en    (o_wb_valid),
        .i_wr_data  (o_wb_data),
        .o_rs1_data (rf_rs1_data),
        .o_rs2_data (rf_rs2_data)
    );

    execute_stage u_ex (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_rs1_addr  (dec_rs1_addr),
        .i_rs2_addr  (dec_rs2_addr),
        .i_rd_addr   (dec_rd_addr),
        .i_rs1_data  (rf_rs1_data),
        .i_rs2_data  (rf_rs2_data),
        .i_imm       (dec_imm),
        .i_alu_op    (dec_alu_op),
        .i_use_imm   (dec_use_imm),
        .i_reg_write (dec_reg_write),
        .o_wb_valid  (o_wb_valid),
        .o_wb_rd     (o_wb_rd),
        .o_wb_data   (o_wb_data)
    );

endmodule

// File: execute/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t i_rs1_addr,
    input  reg_addr_t i_rs2_addr,
    input  reg_addr_t i_rd_addr,
    input  word_t     i_rs1_data,
    input  word_t     i_rs2_data,
    input  word_t     i_imm,
    input  alu_op_e   i_alu_op,
    input  logic      i_use_imm,
    input  logic      i_reg_write,
    output logic      o_wb_valid,
    output reg_addr_t o_wb_rd,
    output word_t     o_wb_data
);

    // decode to execute register
    reg_addr_t de_rs1_addr;
    reg_addr_t de_rs2_addr;
    reg_addr_t de_rd_addr;
    alu_op_e   de_alu_op;
    logic      de_use_imm;
    logic      de_reg_write;
    word_t     de_rs1_data;
    word_t     de_rs2_data;
    word_t     de_imm;

    word_t op_a;
    word_t op_b_reg;
    word_t op_b;
    word_t alu_out;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            de_rs1_addr  <= '0;
            de_rs2_addr  <= '0;
            de_rd_addr   <= '0;
            de_alu_op    <= ALU_ADD;
            de_use_imm   <= 1'b0;
            de_reg_write <= 1'b0;
        end else begin
            de_rs1_addr  <= i_rs1_addr;
            de_rs2_addr  <= i_rs2_addr;
            de_rd_addr   <= i_rd_addr;
            de_alu_op    <= i_alu_op;
            de_use_imm   <= i_use_imm;
            de_reg_write <= i_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        de_rs1_data <= i_rs1_data;
        de_rs2_data <= i_rs2_data;
        de_imm      <= i_imm;
    end

    // forward from the writeback register, older results come via the regfile
    assign op_a     = (o_wb_valid && (o_wb_rd == de_rs1_addr)) ? o_wb_data : de_rs1_data;
    assign op_b_reg = (o_wb_valid && (o_wb_rd == de_rs2_addr)) ? o_wb_data : de_rs2_data;
    assign op_b     = de_use_imm ? de_imm : op_b_reg;

    always_comb begin
        case (de_alu_op)
            ALU_ADD: alu_out = op_a + op_b;
            ALU_SUB: alu_out = op_a - op_b;
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_SLT: alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_XOR: alu_out = op_a ^ op_b;
            ALU_SLL: alu_out = op_a << op_b[4:0];
            ALU_SRA: alu_out = $signed(op_a) >>> op_b[4:0];
            ALU_SRL: alu_out = op_a >> op_b[4:0];
            default: alu_out = op_a + op_b;
        endcase
    end

    // writeback register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_wb_valid <= 1'b0;
            o_wb_rd    <= '0;
        end else begin
            o_wb_valid <= de_reg_write;
            o_wb_rd    <= de_rd_addr;
        end
    end

    always_ff @(posedge clk) begin
        o_wb_data <= alu_out;
    end

    // rd of zero is filtered two stages earlier in the decoder
    a_wb_rd_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n)
        o_wb_valid |-> (o_wb_rd != '0)
    );

    a_ctrl_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown({o_wb_valid, o_wb_rd, de_reg_write, de_alu_op, de_use_imm})
    );

endmodule

// File: decode/reg_file.sv
`timescale 1ns/1ps

module reg_file
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t i_rs1_addr,
    input  reg_addr_t i_rs2_addr,
    input  reg_addr_t i_wr_addr,
    input  logic      i_wr_en,
    input  word_t     i_wr_data,
    output word_t     o_rs1_data,
    output word_t     o_rs2_data
);

    word_t regs [1:31]; // x0 has no storage

    // read port with write-through from the port being written this cycle
    function automatic word_t read_port(input reg_addr_t addr);
        word_t data;
        if (addr == '0) begin
            data = '0;
        end else if (i_wr_en && (i_wr_addr == addr)) begin
            data = i_wr_data;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    assign o_rs1_data = read_port(i_rs1_addr);
    assign o_rs2_data = read_port(i_rs2_addr);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_addr != '0)) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    a_x0_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        ((i_rs1_addr != '0) || (o_rs1_data == '0)) &&
        ((i_rs2_addr != '0) || (o_rs2_data == '0))
    );

endmodule

// File: decode/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder
    import rv_pkg::*;
(
    input  word_t     i_inst,
    output reg_addr_t o_rs1_addr,
    output reg_addr_t o_rs2_addr,
    output reg_addr_t o_rd_addr,
    output word_t     o_imm,
    output alu_op_e   o_alu_op,
    output logic      o_use_imm,
    output logic      o_reg_write
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;       // inst[30], picks sub / sra
    logic       is_op;
    logic       is_op_imm;

    assign opcode    = i_inst[6:0];
    assign funct3    = i_inst[14:12];
    assign alt       = i_inst[30];
    assign is_op     = (opcode == OPC_OP);
    assign is_op_imm = (opcode == OPC_OP_IMM);

    assign o_rd_addr  = i_inst[11:7];
    assign o_rs1_addr = i_inst[19:15];
    assign o_rs2_addr = i_inst[24:20]; // junk for I-type, masked by use_imm

    // I-type immediate, sign-extended
    assign o_imm = {{20{i_inst[31]}}, i_inst[31:20]};

    assign o_use_imm = is_op_imm;

    // writes to x0 are dropped here so later stages never see them
    assign o_reg_write = (is_op || is_op_imm) && (o_rd_addr != '0);

    always_comb begin
        case (funct3)
            3'b000: begin
                // addi with a negative imm also has bit 30 set
                o_alu_op = (alt && is_op) ? ALU_SUB : ALU_ADD;
            end
            3'b001: o_alu_op = ALU_SLL;
            3'b010: o_alu_op = ALU_SLT;
            3'b100: o_alu_op = ALU_XOR;
            3'b101: begin
                o_alu_op = alt ? ALU_SRA : ALU_SRL;
            end
            3'b110: o_alu_op = ALU_OR;
            3'b111: o_alu_op = ALU_AND;
            default: o_alu_op = ALU_ADD; // sltu not implemented
        endcase
    end

endmodule

// File: fetch/fetch_stage.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module fetch_stage
    import rv_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  word_t      i_imem_rdata,
    input  logic       i_imem_stall,
    output imem_addr_t o_imem_addr,
    output word_t      o_pc,
    output word_t      o_inst
);

    word_t pc_r;
    word_t inst_r;
    word_t inst_swapped;

    // memory word comes back byte-reversed
    assign inst_swapped = {i_imem_rdata[7:0], i_imem_rdata[15:8],
                           i_imem_rdata[23:16], i_imem_rdata[31:24]};

    assign o_imem_addr = pc_r[31:2];
    assign o_pc        = pc_r;
    assign o_inst      = inst_r;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_r <= `RV_RESET_PC;
        end else if (!i_imem_stall) begin
            pc_r <= pc_r + 32'd4; // no branches, always sequential
        end
    end

    // fetch register, a stalled cycle turns into a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst_r <= `RV_NOP;
        end else if (i_imem_stall) begin
            inst_r <= `RV_NOP;
        end else begin
            inst_r <= inst_swapped;
        end
    end

    // the same word is requested again after a stall
    a_pc_hold_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        i_imem_stall |=> $stable(pc_r)
    );

endmodule

// File: common/rv_pkg.sv
`include "rv_defs.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]   word_t;      // data, instruction or pc
    typedef logic [`RV_REG_AW-1:0] reg_addr_t;
    typedef logic [`RV_XLEN-3:0]   imem_addr_t; // word address, pc[31:2]

    // only the two ALU opcodes are executed
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'b0000,
        ALU_SUB = 4'b0001,
        ALU_AND = 4'b0010,
        ALU_OR  = 4'b0011,
        ALU_SLT = 4'b0100,
        ALU_XOR = 4'b0101,
        ALU_SLL = 4'b0110,
        ALU_SRA = 4'b0111,
        ALU_SRL = 4'b1000
    } alu_op_e;

endpackage

// File: common/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// datapath width
`define RV_XLEN 32

// 32 architectural registers
`define RV_REG_AW 5

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

// first fetch address
`define RV_RESET_PC 32'h0000_0000

`endif
